/* exec_pkg.sv */
package exec_pkg;

  localparam int XLEN    = 64;
  localparam int NUM_BUS = 4;  // Result buses forwarded into the lane
  localparam int SHAMT_W = 6;

  typedef logic [XLEN-1:0] word_t;

  // 0 picks the register-file value, k picks bus k-1
  typedef logic [2:0] fwd_sel_t;

  typedef enum logic [3:0] {
    OP_ADD64 = 4'd0,
    OP_ADD32 = 4'd1,
    OP_SUB64 = 4'd2,
    OP_SUB32 = 4'd3,
    OP_AND   = 4'd4,
    OP_OR    = 4'd5,
    OP_XOR   = 4'd6,
    OP_SHL64 = 4'd7,
    OP_SHL32 = 4'd8,
    OP_SHR64 = 4'd9,
    OP_SHR32 = 4'd10,
    OP_SAR64 = 4'd11,
    OP_SAR32 = 4'd12
  } op_t;

  typedef enum logic [1:0] {
    FN_ADD = 2'd0,
    FN_AND = 2'd1,
    FN_OR  = 2'd2,
    FN_XOR = 2'd3
  } logic_fn_t;

endpackage

/* operand_fwd.sv */
module operand_fwd import exec_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     issue,
  input  word_t    reg_val,
  input  fwd_sel_t sel,
  input  logic     late,
  input  word_t    bus_data [NUM_BUS],
  output word_t    operand
);

  word_t bus_dly [NUM_BUS];
  word_t next_val;

  // One-cycle copy of every bus for late forwarding
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_BUS; i++) begin
        bus_dly[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_BUS; i++) begin
        bus_dly[i] <= bus_data[i];
      end
    end
  end

  always_comb begin
    next_val = reg_val;  // Select values past the last bus fall back to the register file
    for (int i = 0; i < NUM_BUS; i++) begin
      if (sel == fwd_sel_t'(i + 1)) begin
        next_val = late ? bus_dly[i] : bus_data[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      operand <= '0;
    end else if (issue) begin
      operand <= next_val;  // Holds between issues
    end
  end

endmodule

/* op_decode.sv */
module op_decode import exec_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      valid,
  input  op_t       op,
  output logic      stage_valid,
  output logic      is_sub,
  output logic_fn_t logic_fn,
  output logic      is_word32,
  output logic      use_shift,
  output logic      shift_right,
  output logic      shift_arith
);

  logic      sub_d;
  logic_fn_t fn_d;
  logic      w32_d;
  logic      shift_d;
  logic      right_d;
  logic      arith_d;

  always_comb begin
    sub_d   = 1'b0;
    fn_d    = FN_ADD;
    w32_d   = 1'b0;
    shift_d = 1'b0;
    right_d = 1'b0;
    arith_d = 1'b0;
    case (op)
      OP_ADD32: begin
        w32_d = 1'b1;
      end
      OP_SUB64: begin
        sub_d = 1'b1;
      end
      OP_SUB32: begin
        sub_d = 1'b1;
        w32_d = 1'b1;
      end
      OP_AND: fn_d = FN_AND;
      OP_OR:  fn_d = FN_OR;
      OP_XOR: fn_d = FN_XOR;
      OP_SHL64: begin
        shift_d = 1'b1;
      end
      OP_SHL32: begin
        shift_d = 1'b1;
        w32_d   = 1'b1;
      end
      OP_SHR64: begin
        shift_d = 1'b1;
        right_d = 1'b1;
      end
      OP_SHR32: begin
        shift_d = 1'b1;
        right_d = 1'b1;
        w32_d   = 1'b1;
      end
      OP_SAR64: begin
        shift_d = 1'b1;
        right_d = 1'b1;
        arith_d = 1'b1;
      end
      OP_SAR32: begin
        shift_d = 1'b1;
        right_d = 1'b1;
        arith_d = 1'b1;
        w32_d   = 1'b1;
      end
      default: ;  // ADD64 and the unused codes keep the plain 64-bit add
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stage_valid <= 1'b0;
      is_sub      <= 1'b0;
      logic_fn    <= FN_ADD;
      is_word32   <= 1'b0;
      use_shift   <= 1'b0;
      shift_right <= 1'b0;
      shift_arith <= 1'b0;
    end else begin
      stage_valid <= valid;
      if (valid) begin
        is_sub      <= sub_d;
        logic_fn    <= fn_d;
        is_word32   <= w32_d;
        use_shift   <= shift_d;
        shift_right <= right_d;
        shift_arith <= arith_d;
      end
    end
  end

endmodule

/* alu_addlog.sv */
module alu_addlog import exec_pkg::*; (
  input  word_t     a,
  input  word_t     b,
  input  logic      is_sub,
  input  logic_fn_t logic_fn,
  input  logic      is_word32,
  output word_t     result
);

  word_t b_op;
  word_t sum;
  word_t raw;

  // Subtract as a + ~b + 1
  assign b_op = is_sub ? ~b : b;
  assign sum  = a + b_op + word_t'(is_sub);

  always_comb begin
    case (logic_fn)
      FN_AND:  raw = a & b;
      FN_OR:   raw = a | b;
      FN_XOR:  raw = a ^ b;
      default: raw = sum;
    endcase
  end

  // 32-bit forms only keep the low word
  assign result = is_word32 ? {{(XLEN/2){1'b0}}, raw[XLEN/2-1:0]} : raw;

endmodule

/* alu_shift.sv */
module alu_shift import exec_pkg::*; (
  input  word_t              a,
  input  logic [SHAMT_W-1:0] shamt,
  input  logic               is_word32,
  input  logic               shift_right,
  input  logic               shift_arith,
  output word_t              result
);

  logic               sign32;
  logic               fill;
  logic [SHAMT_W-1:0] amt;
  word_t              src;
  word_t              stg [SHAMT_W+1];

  // In 32-bit mode the upper half already carries the fill so right shifts bring it in
  assign sign32 = shift_arith & a[XLEN/2-1];
  assign src    = is_word32 ? {{(XLEN/2){sign32}}, a[XLEN/2-1:0]} : a;
  assign fill   = shift_arith & src[XLEN-1];
  assign amt    = is_word32 ? {1'b0, shamt[SHAMT_W-2:0]} : shamt;

  assign stg[0] = src;

  // Stage i moves the word by 2**i when amount bit i is set
  for (genvar i = 0; i < SHAMT_W; i++) begin : g_stage
    word_t moved;

    assign moved = shift_right ?
                   {{(1 << i){fill}}, stg[i][XLEN-1:(1 << i)]} :
                   {stg[i][XLEN-1-(1 << i):0], {(1 << i){1'b0}}};
    assign stg[i+1] = amt[i] ? moved : stg[i];
  end

  assign result = is_word32 ? {{(XLEN/2){1'b0}}, stg[SHAMT_W][XLEN/2-1:0]} :
                  stg[SHAMT_W];

endmodule

/* result_stage.sv */
module result_stage import exec_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  stage_valid,
  input  logic  use_shift,
  input  word_t addlog_res,
  input  word_t shift_res,
  output word_t res,
  output logic  res_valid
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res       <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= stage_valid;
      if (stage_valid) begin
        res <= use_shift ? shift_res : addlog_res;  // Held while the lane is idle
      end
    end
  end

endmodule

/* exec_lane.sv */
module exec_lane import exec_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     valid,
  input  op_t      op,
  input  word_t    a,
  input  word_t    b,
  input  fwd_sel_t a_sel,
  input  logic     a_late,
  input  fwd_sel_t b_sel,
  input  logic     b_late,
  input  word_t    bus_data [NUM_BUS],
  output word_t    res,
  output logic     res_valid
);

  word_t     a_op;
  word_t     b_op;
  logic      stage_valid;
  logic      is_sub;
  logic_fn_t logic_fn;
  logic      is_word32;
  logic      use_shift;
  logic      shift_right;
  logic      shift_arith;
  word_t     addlog_res;
  word_t     shift_res;

  operand_fwd i_fwd_a (
    .clk      (clk),
    .arst_n   (arst_n),
    .issue    (valid),
    .reg_val  (a),
    .sel      (a_sel),
    .late     (a_late),
    .bus_data (bus_data),
    .operand  (a_op)
  );

  operand_fwd i_fwd_b (
    .clk      (clk),
    .arst_n   (arst_n),
    .issue    (valid),
    .reg_val  (b),
    .sel      (b_sel),
    .late     (b_late),
    .bus_data (bus_data),
    .operand  (b_op)
  );

  op_decode i_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .valid       (valid),
    .op          (op),
    .stage_valid (stage_valid),
    .is_sub      (is_sub),
    .logic_fn    (logic_fn),
    .is_word32   (is_word32),
    .use_shift   (use_shift),
    .shift_right (shift_right),
    .shift_arith (shift_arith)
  );

  alu_addlog i_addlog (
    .a         (a_op),
    .b         (b_op),
    .is_sub    (is_sub),
    .logic_fn  (logic_fn),
    .is_word32 (is_word32),
    .result    (addlog_res)
  );

  // Shift amount comes straight from the low bits of the B operand
  alu_shift i_shift (
    .a           (a_op),
    .shamt       (b_op[SHAMT_W-1:0]),
    .is_word32   (is_word32),
    .shift_right (shift_right),
    .shift_arith (shift_arith),
    .result      (shift_res)
  );

  result_stage i_result (
    .clk         (clk),
    .arst_n      (arst_n),
    .stage_valid (stage_valid),
    .use_shift   (use_shift),
    .addlog_res  (addlog_res),
    .shift_res   (shift_res),
    .res         (res),
    .res_valid   (res_valid)
  );

endmodule

/* tb_exec_lane.sv */
module tb_exec_lane import exec_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_LINES = 256;
  localparam int FIELDS    = 9;  // valid op a b a_sel a_late b_sel b_late expected

  typedef struct packed {
    logic [31:0] due;
    word_t       model_val;
    logic        file_ok;
    word_t       file_val;
  } pend_t;

  logic     clk;
  logic     arst_n;
  logic     valid;
  op_t      op;
  word_t    a;
  word_t    b;
  fwd_sel_t a_sel;
  logic     a_late;
  fwd_sel_t b_sel;
  logic     b_late;
  word_t    bus_data [NUM_BUS];
  word_t    res;
  logic     res_valid;

  logic [63:0] vec_mem [MAX_LINES*FIELDS];
  word_t       bus_now [NUM_BUS];
  word_t       bus_prev [NUM_BUS];  // What the delay registers hold at the next edge
  logic [31:0] seed;
  logic [31:0] cyc;
  pend_t       pend_q [$];
  int          n_lines;
  logic        loaded = 1'b0;
  int          val_errs = 0;
  int          seq_errs = 0;

  exec_lane i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid     (valid),
    .op        (op),
    .a         (a),
    .b         (b),
    .a_sel     (a_sel),
    .a_late    (a_late),
    .b_sel     (b_sel),
    .b_late    (b_late),
    .bus_data  (bus_data),
    .res       (res),
    .res_valid (res_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected result straight from the operation rules
  function automatic word_t model_result(input op_t f, input word_t x, input word_t y);
    logic signed [31:0] s32;
    logic [5:0]         sh64;
    logic [4:0]         sh32;
    word_t              r;
    s32  = x[31:0];
    sh64 = y[5:0];
    sh32 = y[4:0];
    case (f)
      OP_ADD32: r = {32'h0, x[31:0] + y[31:0]};
      OP_SUB64: r = x - y;
      OP_SUB32: r = {32'h0, x[31:0] - y[31:0]};
      OP_AND:   r = x & y;
      OP_OR:    r = x | y;
      OP_XOR:   r = x ^ y;
      OP_SHL64: r = x << sh64;
      OP_SHL32: r = {32'h0, x[31:0] << sh32};
      OP_SHR64: r = x >> sh64;
      OP_SHR32: r = {32'h0, x[31:0] >> sh32};
      OP_SAR64: r = $signed(x) >>> sh64;
      OP_SAR32: r = {32'h0, s32 >>> sh32};
      default:  r = x + y;
    endcase
    return r;
  endfunction

  function automatic word_t pick_operand(input word_t reg_val, input fwd_sel_t sel,
                                         input logic late);
    int idx;
    idx = int'(sel) - 1;
    if (idx < 0 || idx >= NUM_BUS) begin
      return reg_val;
    end
    return late ? bus_prev[idx] : bus_now[idx];
  endfunction

  task automatic step_buses();
    logic [31:0] hi;
    for (int k = 0; k < NUM_BUS; k++) begin
      bus_prev[k] = bus_now[k];
      seed        = lcg_next(seed);
      hi          = seed;
      seed        = lcg_next(seed);
      bus_now[k]  = {hi, seed};
      bus_data[k] <= bus_now[k];
    end
  endtask

  task automatic apply_line(input int idx);
    int       base;
    op_t      f_op;
    fwd_sel_t f_asel;
    fwd_sel_t f_bsel;
    pend_t    entry;
    word_t    op_a;
    word_t    op_b;
    base   = idx * FIELDS;
    f_op   = op_t'(vec_mem[base+1][3:0]);
    f_asel = vec_mem[base+4][2:0];
    f_bsel = vec_mem[base+6][2:0];
    valid  <= vec_mem[base][0];
    op     <= f_op;
    a      <= vec_mem[base+2];
    b      <= vec_mem[base+3];
    a_sel  <= f_asel;
    a_late <= vec_mem[base+5][0];
    b_sel  <= f_bsel;
    b_late <= vec_mem[base+7][0];
    if (vec_mem[base][0]) begin
      op_a            = pick_operand(vec_mem[base+2], f_asel, vec_mem[base+5][0]);
      op_b            = pick_operand(vec_mem[base+3], f_bsel, vec_mem[base+7][0]);
      entry.due       = cyc + 32'd2;  // Issue at the next edge, result one edge after that
      entry.model_val = model_result(f_op, op_a, op_b);
      entry.file_ok   = (f_asel == 3'd0) && (f_bsel == 3'd0);
      entry.file_val  = vec_mem[base+8];
      pend_q.push_back(entry);
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED %s at cycle %0d: got %h, expected %h", name, cyc, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s at cycle %0d: got %h, expected %h", name, cyc, got, exp);
      val_errs++;
    end
  endtask

  always @(negedge clk) begin : check_results
    pend_t head;
    logic  due_now;
    due_now = 1'b0;
    if (pend_q.size() != 0) begin
      due_now = (pend_q[0].due <= cyc);
    end
    check_bit("res_valid", res_valid, due_now);
    if (due_now) begin
      head = pend_q.pop_front();
      if (res_valid) begin
        check_word("res", res, head.model_val);
        if (head.file_ok) begin
          check_word("res (file column)", res, head.file_val);
        end
      end else begin
        $display("Result due at cycle %0d did not arrive", head.due);
        seq_errs++;
      end
    end else if (res_valid) begin
      $display("Unexpected result at cycle %0d with no op in flight", cyc);
      seq_errs++;
    end
  end

  initial begin : drive_tests
    arst_n <= 1'b0;
    valid  <= 1'b0;
    op     <= OP_ADD64;
    a      <= '0;
    b      <= '0;
    a_sel  <= '0;
    a_late <= 1'b0;
    b_sel  <= '0;
    b_late <= 1'b0;
    for (int k = 0; k < NUM_BUS; k++) begin
      bus_data[k] <= '0;
      bus_now[k]  = '0;
      bus_prev[k] = '0;
    end
    seed = 32'h7b68;
    cyc  = '0;
    $readmemh("exec_tests.mem", vec_mem);
    n_lines = 0;
    while (n_lines < MAX_LINES && vec_mem[n_lines*FIELDS] != 64'hf) begin
      n_lines++;  // A valid column of f marks the end of the tests
    end
    loaded = 1'b1;
    repeat (3) begin
      @(posedge clk);
      cyc = cyc + 32'd1;
      step_buses();
    end
    arst_n <= 1'b1;
    for (int i = 0; i < n_lines; i++) begin
      @(posedge clk);
      cyc = cyc + 32'd1;
      step_buses();
      apply_line(i);
    end
    repeat (4) begin
      @(posedge clk);
      cyc = cyc + 32'd1;
      step_buses();
      valid <= 1'b0;
    end
    @(negedge clk);
    #1;
    $display("Errors: %0d value, %0d sequence", val_errs, seq_errs);
    if (val_errs == 0 && seq_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    #((n_lines + 10) * 100);
    $display("Watchdog expired before the %0d test lines completed", n_lines);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* exec_tests.mem */
// Columns: valid op a b a_sel a_late b_sel b_late expected
// Op codes: 0 add64 1 add32 2 sub64 3 sub32 4 and 5 or 6 xor 7 shl64 8 shl32
// 9 shr64 a shr32 b sar64 c sar32, expected only counts when both selects are 0
0 0 0000000000000000 0000000000000000 0 0 0 0 0000000000000000
0 0 0000000000000000 0000000000000000 0 0 0 0 0000000000000000
1 0 0000000000000005 0000000000000003 0 0 0 0 0000000000000008
1 0 ffffffffffffffff 0000000000000002 0 0 0 0 0000000000000001
1 1 12345678fffffff0 0000000100000020 0 0 0 0 0000000000000010
1 1 aaaaaaaa7fffffff 5555555500000001 0 0 0 0 0000000080000000
1 2 0000000000000003 0000000000000005 0 0 0 0 fffffffffffffffe
1 2 123456789abcdef0 0fedcba987654321 0 0 0 0 02468acf13579bcf
1 3 ffffffff00000000 0000000000000001 0 0 0 0 00000000ffffffff
1 3 1111111100000010 2222222200000010 0 0 0 0 0000000000000000
1 4 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 0 0 0 f000f000f000f000
1 5 f0f0f0f000000000 0f0f0f0f12345678 0 0 0 0 ffffffff12345678
1 6 aaaaaaaaaaaaaaaa ffffffff00000000 0 0 0 0 55555555aaaaaaaa
1 7 8000000000000001 0000000000000000 0 0 0 0 8000000000000001
1 7 0000000000000003 000000000000003f 0 0 0 0 8000000000000000
1 7 0123456789abcdef ffffffffffffff04 0 0 0 0 123456789abcdef0
1 8 ffffffff00000003 000000000000001f 0 0 0 0 0000000080000000
1 8 ffffffff12345678 0000000000000020 0 0 0 0 0000000012345678
1 8 0000000080000001 0000000000000021 0 0 0 0 0000000000000002
1 9 8000000000000000 000000000000003f 0 0 0 0 0000000000000001
1 9 123456789abcdef0 0000000000000020 0 0 0 0 0000000012345678
1 a 1234567880000000 000000000000001f 0 0 0 0 0000000000000001
1 a ffffffff87654321 0000000000000004 0 0 0 0 0000000008765432
1 b 8000000000000000 0000000000000004 0 0 0 0 f800000000000000
1 b 8000000000000000 000000000000003f 0 0 0 0 ffffffffffffffff
1 b 7000000000000000 000000000000003c 0 0 0 0 0000000000000007
1 c 0000000080000000 000000000000001f 0 0 0 0 00000000ffffffff
1 c 00000000f0000000 0000000000000020 0 0 0 0 00000000f0000000
1 c 12345678c0000000 0000000000000004 0 0 0 0 00000000fc000000
1 c ffffffff40000000 0000000000000008 0 0 0 0 0000000000400000
1 d 0000000000000010 0000000000000020 0 0 0 0 0000000000000030
0 2 ffffffffffffffff 0000000000000001 1 1 2 1 0000000000000000
1 0 1111111111111111 0000000000000000 1 0 0 0 0000000000000000
1 6 0000000000000000 2222222222222222 0 0 4 0 0000000000000000
1 0 3333333333333333 0000000000000000 2 1 0 0 0000000000000000
1 2 0000000000000000 0000000000000000 3 1 2 1 0000000000000000
1 0 0000000000000000 0000000000000000 1 1 1 0 0000000000000000
1 b 0000000000000000 0000000000000004 4 1 0 0 0000000000000000
1 8 0000000000000000 0000000000000000 2 0 3 1 0000000000000000
0 0 0000000000000000 0000000000000000 0 0 0 0 0000000000000000
0 0 0000000000000000 0000000000000000 0 0 0 0 0000000000000000
f 0 0000000000000000 0000000000000000 0 0 0 0 0000000000000000

/* sim.f */
exec_pkg.sv
operand_fwd.sv
op_decode.sv
alu_addlog.sv
alu_shift.sv
result_stage.sv
exec_lane.sv
tb_exec_lane.sv

/* run.sh */
#!/bin/sh
# Builds the exec_lane testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module tb_exec_lane -f sim.f \
  && ./obj_dir/Vtb_exec_lane | tee /dev/stderr | grep -xF "=== PASS ===" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
